// ==== src/sbus_defines.svh ====
`ifndef SBUS_DEFINES_SVH
`define SBUS_DEFINES_SVH

// Memory word as carried on the SBUS
`define WORD_WIDTH 36

// Physical address from the MBOX
`define ADR_WIDTH 22

// Low address bits decoded by the storage module
// Upper bits alias onto the same 256 words
`define STORE_ADR_BITS 8

// Cycles from request acceptance to the data-valid pulse
// Must be at least 2 so data-valid never overlaps ackn
`define READ_LATENCY 3

`endif

// ==== src/sbusPkg.sv ====
`include "sbus_defines.svh"

package sbusPkg;

  // One memory word without parity
  typedef logic [`WORD_WIDTH-1:0] wordT;

  // Physical address as held by the translator
  typedef logic [`ADR_WIDTH-1:0] adrT;

  // MBOX outputs for one cable
  typedef struct packed {
    logic memRq;
    logic rdRq;
    logic wrRq;
    // Loads the translator address register while high
    logic adrHold;
    adrT  pa;
    logic memAdrPar;
    wordT mb;
    logic memPar;
  } mboxReqT;

  // MBOX inputs for one cable
  typedef struct packed {
    logic memAckn;
    logic memDataValid;
    wordT memDataIn;
    logic memParIn;
    // Bad parity on read data
    logic memError;
    logic memAdrParErr;
  } mboxRspT;

  // Request side of the SBUS
  typedef struct packed {
    logic rq;
    logic rdRq;
    logic wrRq;
    adrT  adr;
    logic adrPar;
    wordT d;
    logic dataPar;
  } sbusReqT;

  // Response side of the SBUS, driven by storage
  typedef struct packed {
    logic ackn;
    logic dataValid;
    wordT d;
    logic dataPar;
    logic adrParErr;
  } sbusRspT;

endpackage

// ==== src/mbusTranslator.sv ====
`timescale 1ns/1ns

// Cable-side bus translator between one MBOX and the shared SBUS
// Address is held in a register, everything else passes straight through
module mbusTranslator (
  input  logic             sbusClk,
  input  logic             rstN,
  input  sbusPkg::mboxReqT mbox,
  output sbusPkg::mboxRspT mboxRsp,
  output sbusPkg::sbusReqT sbus,
  input  sbusPkg::sbusRspT sbusRsp
);

  // Held physical address
  sbusPkg::adrT adrReg;

  // Direction of the data path, toward memory on writes
  logic dataToMem;

  // Odd parity check result on returned data
  logic readParOk;

  // Address hold register
  // MBOX raises adrHold ahead of memRq so adr is valid by the request
  always_ff @(posedge sbusClk or negedge rstN) begin
    if (!rstN) begin
      adrReg <= '0;
    end else if (mbox.adrHold) begin
      adrReg <= mbox.pa;
    end
  end

  assign dataToMem = mbox.wrRq;

  // Request strobes and address toward the SBUS
  always_comb begin
    sbus.rq     = mbox.memRq;
    sbus.rdRq   = mbox.rdRq;
    sbus.wrRq   = mbox.wrRq;
    sbus.adr    = adrReg;
    sbus.adrPar = mbox.memAdrPar;
    // Write data only goes out on a write
    sbus.d       = '0;
    sbus.dataPar = 1'b0;
    if (dataToMem) begin
      sbus.d       = mbox.mb;
      sbus.dataPar = mbox.memPar;
    end
  end

  // Word and parity bit together must hold an odd number of ones
  assign readParOk = ^{sbusRsp.d, sbusRsp.dataPar};

  // Responses back toward the MBOX
  always_comb begin
    mboxRsp.memAckn      = sbusRsp.ackn;
    mboxRsp.memDataValid = sbusRsp.dataValid;
    mboxRsp.memAdrParErr = sbusRsp.adrParErr;
    // Flagged in the same cycle as data-valid
    mboxRsp.memError     = sbusRsp.dataValid & ~readParOk;
    mboxRsp.memDataIn = '0;
    mboxRsp.memParIn  = 1'b0;
    if (!dataToMem) begin
      mboxRsp.memDataIn = sbusRsp.d;
      mboxRsp.memParIn  = sbusRsp.dataPar;
    end
  end

  // Exactly one direction per request
  assert property (@(posedge sbusClk) disable iff (!rstN)
    mbox.memRq |-> !(mbox.rdRq && mbox.wrRq))
    else $error("mbusTranslator: rdRq and wrRq both high");

  // memRq is a level that holds until the ackn pulse comes back
  assert property (@(posedge sbusClk) disable iff (!rstN)
    (mbox.memRq && !sbusRsp.ackn) |=> mbox.memRq)
    else $error("mbusTranslator: memRq dropped before memAckn");

endmodule

// ==== src/sbusArbiter.sv ====
`timescale 1ns/1ns

// Round-robin owner of the single SBUS
// Grant holds from request to completion of the whole transfer
module sbusArbiter (
  input  logic             sbusClk,
  input  logic             rstN,
  input  sbusPkg::sbusReqT req0,
  input  sbusPkg::sbusReqT req1,
  output sbusPkg::sbusRspT rsp0,
  output sbusPkg::sbusRspT rsp1,
  output sbusPkg::sbusReqT bus,
  input  sbusPkg::sbusRspT busRsp
);

  // One-hot grant register, bit n for cable n
  logic [1:0] grant;
  // Cable served by the last completed transfer
  logic lastServed;
  // Granted transfer is a read, waits for data-valid
  logic isRead;
  logic [1:0] newGrant;
  logic [1:0] grantNow;
  logic done;

  // Pick for an idle bus, the other cable wins a tie
  always_comb begin
    newGrant = 2'b00;
    if (req0.rq && req1.rq) begin
      newGrant = lastServed ? 2'b01 : 2'b10;
    end else if (req0.rq) begin
      newGrant = 2'b01;
    end else if (req1.rq) begin
      newGrant = 2'b10;
    end
  end

  // Idle bus grants in the same cycle the request appears
  assign grantNow = (grant != 2'b00) ? grant : newGrant;

  // Writes and address errors finish on ackn, reads on data-valid
  assign done = (grant != 2'b00) &&
                ((busRsp.ackn && (!isRead || busRsp.adrParErr)) || busRsp.dataValid);

  always_ff @(posedge sbusClk or negedge rstN) begin
    if (!rstN) begin
      grant      <= 2'b00;
      lastServed <= 1'b1;
      isRead     <= 1'b0;
    end else if (done) begin
      grant      <= 2'b00;
      lastServed <= grant[1];
    end else if (grant == 2'b00 && newGrant != 2'b00) begin
      grant  <= newGrant;
      isRead <= newGrant[1] ? req1.rdRq : req0.rdRq;
    end
  end

  // Request mux and response demux
  assign bus  = grantNow[1] ? req1 : (grantNow[0] ? req0 : '0);
  assign rsp0 = grantNow[0] ? busRsp : '0;
  assign rsp1 = grantNow[1] ? busRsp : '0;

  assert property (@(posedge sbusClk) disable iff (!rstN)
    $onehot0(grantNow))
    else $error("sbusArbiter: both cables granted");

endmodule

// ==== src/storageModule.sv ====
`timescale 1ns/1ns
`include "sbus_defines.svh"

// SBUS memory, one word plus its parity bit per location
// Every request gets ackn, reads get data after a fixed latency
module storageModule (
  input  logic             sbusClk,
  input  logic             rstN,
  input  sbusPkg::sbusReqT bus,
  output sbusPkg::sbusRspT busRsp
);

  localparam int memDepth = 1 << `STORE_ADR_BITS;
  localparam int cntWidth = $clog2(`READ_LATENCY + 1);

  // Word array and the parity stored alongside each word
  sbusPkg::wordT memData [memDepth];
  logic          memPar  [memDepth];

  logic                       busy;
  logic                       rdActive;
  logic [cntWidth-1:0]        cnt;
  logic                       ackn;
  logic                       dataValid;
  logic                       adrParErr;
  logic                       accept;
  logic                       adrBad;
  logic [`STORE_ADR_BITS-1:0] idx;
  logic [`STORE_ADR_BITS-1:0] rdIdx;
  sbusPkg::wordT              rdData;
  logic                       rdPar;

  assign accept = !busy && bus.rq;
  // Odd parity over the full address
  assign adrBad = ~^{bus.adr, bus.adrPar};
  // Only the low bits select a word
  assign idx    = bus.adr[`STORE_ADR_BITS-1:0];

  // Request sequencing and response pulses
  always_ff @(posedge sbusClk or negedge rstN) begin
    if (!rstN) begin
      busy      <= 1'b0;
      rdActive  <= 1'b0;
      cnt       <= '0;
      ackn      <= 1'b0;
      dataValid <= 1'b0;
      adrParErr <= 1'b0;
    end else begin
      ackn      <= 1'b0;
      dataValid <= 1'b0;
      adrParErr <= 1'b0;
      if (accept) begin
        busy      <= 1'b1;
        ackn      <= 1'b1;
        adrParErr <= adrBad;
        // Bad address gets no data phase
        if (!adrBad && bus.rdRq) begin
          rdActive <= 1'b1;
          cnt      <= cntWidth'(`READ_LATENCY - 1);
        end
      end else if (rdActive) begin
        if (cnt == cntWidth'(1)) begin
          dataValid <= 1'b1;
          rdActive  <= 1'b0;
        end
        cnt <= cnt - 1'b1;
      end else if (ackn || dataValid) begin
        // Last response pulse ends the busy window
        busy <= 1'b0;
      end
    end
  end

  // Array write at acceptance, read word captured for data-valid
  always_ff @(posedge sbusClk) begin
    if (accept && bus.wrRq && !adrBad) begin
      memData[idx] <= bus.d;
      memPar[idx]  <= bus.dataPar;
    end
    if (accept) begin
      rdIdx <= idx;
    end
    if (rdActive && cnt == cntWidth'(1)) begin
      rdData <= memData[rdIdx];
      rdPar  <= memPar[rdIdx];
    end
  end

  always_comb begin
    busRsp.ackn      = ackn;
    busRsp.dataValid = dataValid;
    busRsp.adrParErr = adrParErr;
    busRsp.d         = rdData;
    busRsp.dataPar   = rdPar;
  end

  assert property (@(posedge sbusClk) disable iff (!rstN)
    !(ackn && dataValid))
    else $error("storageModule: ackn and dataValid together");

  // Data-valid lands a fixed distance after the matching ackn
  assert property (@(posedge sbusClk) disable iff (!rstN)
    $rose(dataValid) |-> $past(ackn, `READ_LATENCY - 1))
    else $error("storageModule: dataValid out of step with ackn");

endmodule

// ==== src/memSubsystem.sv ====
`timescale 1ns/1ns

// Two MBOX cables sharing one storage module over the SBUS
module memSubsystem (
  input  logic             sbusClk,
  input  logic             rstN,
  input  sbusPkg::mboxReqT mbox0,
  input  sbusPkg::mboxReqT mbox1,
  output sbusPkg::mboxRspT mboxRsp0,
  output sbusPkg::mboxRspT mboxRsp1
);

  // Translator side of each cable
  sbusPkg::sbusReqT sbusReq0;
  sbusPkg::sbusReqT sbusReq1;
  sbusPkg::sbusRspT sbusRsp0;
  sbusPkg::sbusRspT sbusRsp1;

  // Shared bus after the arbiter
  sbusPkg::sbusReqT busReq;
  sbusPkg::sbusRspT busRsp;

  mbusTranslator mbusTranslator0_inst (
    .sbusClk (sbusClk),
    .rstN    (rstN),
    .mbox    (mbox0),
    .mboxRsp (mboxRsp0),
    .sbus    (sbusReq0),
    .sbusRsp (sbusRsp0)
  );

  mbusTranslator mbusTranslator1_inst (
    .sbusClk (sbusClk),
    .rstN    (rstN),
    .mbox    (mbox1),
    .mboxRsp (mboxRsp1),
    .sbus    (sbusReq1),
    .sbusRsp (sbusRsp1)
  );

  sbusArbiter sbusArbiter_inst (
    .sbusClk (sbusClk),
    .rstN    (rstN),
    .req0    (sbusReq0),
    .req1    (sbusReq1),
    .rsp0    (sbusRsp0),
    .rsp1    (sbusRsp1),
    .bus     (busReq),
    .busRsp  (busRsp)
  );

  storageModule storageModule_inst (
    .sbusClk (sbusClk),
    .rstN    (rstN),
    .bus     (busReq),
    .busRsp  (busRsp)
  );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ns

// SBUS clock at 100 ns and a reset held for the first two edges
module clockGen (
  output logic sbusClk,
  output logic rstN
);

  initial begin
    sbusClk = 1'b0;
    forever #50 sbusClk = ~sbusClk;
  end

  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge sbusClk);
    rstN <= 1'b1;
  end

endmodule

// ==== test/memSubsystemTb.sv ====
`timescale 1ns/1ns
`include "sbus_defines.svh"

module memSubsystemTb;

  // About 40 operations of up to 2 transfers of 6 cycles, six times over
  localparam int opCount = 40;
  localparam int timeoutCycles = opCount * 2 * 6 * 6 + 120;
  // Longest wait for one response pulse
  localparam int rspWait = 40;

  typedef struct packed {
    sbusPkg::wordT word;
    logic par;
    logic memError;
    logic adrParErr;
  } refT;

  logic sbusClk;
  logic rstN;
  sbusPkg::mboxReqT mbox0;
  sbusPkg::mboxReqT mbox1;
  sbusPkg::mboxRspT mboxRsp0;
  sbusPkg::mboxRspT mboxRsp1;

  // Model of the shared storage, same aliasing as the DUT
  sbusPkg::wordT modelData [1 << `STORE_ADR_BITS];
  logic modelPar [1 << `STORE_ADR_BITS];

  // One command slot and one outstanding transfer per cable
  sbusPkg::mboxReqT cmd [2];
  logic cmdValid [2];
  logic drvBusy [2];
  logic pendActive [2];
  logic inFlight [2];
  logic pendUncont [2];
  sbusPkg::mboxReqT pendReq [2];
  int rqCycle [2];
  int acknCycle [2];
  // Cables in order of completed transfers
  int doneOrder [$];
  // Round-robin state as the arbiter rule predicts it
  logic lastServed;
  int cycle = 0;
  int checks = 0;
  int valueErrors = 0;
  int protoErrors = 0;
  logic [31:0] rngState = 32'd62509;

  clockGen clockGen_inst (
    .sbusClk (sbusClk),
    .rstN    (rstN)
  );

  memSubsystem memSubsystem_inst (
    .sbusClk  (sbusClk),
    .rstN     (rstN),
    .mbox0    (mbox0),
    .mbox1    (mbox1),
    .mboxRsp0 (mboxRsp0),
    .mboxRsp1 (mboxRsp1)
  );

  always @(posedge sbusClk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  // High LCG bits, the low ones repeat too soon
  function automatic sbusPkg::adrT randAdr();
    logic [31:0] r;
    r = nextRand();
    return r[31 -: `ADR_WIDTH];
  endfunction

  function automatic sbusPkg::wordT randWord();
    logic [63:0] r;
    r = {nextRand(), nextRand()};
    return r[63 -: `WORD_WIDTH];
  endfunction

  // Expected read result and address error from the model
  function automatic refT refRead(input sbusPkg::adrT adr, input logic adrPar);
    refT r;
    r.word = modelData[adr[`STORE_ADR_BITS-1:0]];
    r.par = modelPar[adr[`STORE_ADR_BITS-1:0]];
    // Word plus parity must hold an odd count of ones
    r.memError = ~^{r.word, r.par};
    r.adrParErr = ~^{adr, adrPar};
    return r;
  endfunction

  function automatic void modelWrite(input sbusPkg::mboxReqT req);
    modelData[req.pa[`STORE_ADR_BITS-1:0]] = req.mb;
    modelPar[req.pa[`STORE_ADR_BITS-1:0]] = req.memPar;
  endfunction

  task automatic checkWord(input string name, input sbusPkg::wordT exp, input sbusPkg::wordT act);
    checks++;
    if (act !== exp) begin
      valueErrors++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      valueErrors++;
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic checkNumber(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      valueErrors++;
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  function automatic sbusPkg::mboxRspT cableRsp(input int c);
    return (c == 0) ? mboxRsp0 : mboxRsp1;
  endfunction

  task automatic driveCable(input int c, input sbusPkg::mboxReqT req);
    if (c == 0) begin
      mbox0 <= req;
    end else begin
      mbox1 <= req;
    end
  endtask

  task automatic finishTransfer(input int c);
    pendActive[c] = 1'b0;
    inFlight[c] = 1'b0;
    lastServed = c[0];
    doneOrder.push_back(c);
  endtask

  // MBOX side of one cable: adrHold first, then memRq until memAckn
  task automatic runCable(input int c);
    sbusPkg::mboxReqT req;
    sbusPkg::mboxRspT rsp;
    int waited;
    forever begin
      @(posedge sbusClk);
      if (cmdValid[c]) begin
        cmdValid[c] = 1'b0;
        drvBusy[c] = 1'b1;
        req = cmd[c];
        req.adrHold = 1'b1;
        driveCable(c, req);
        @(posedge sbusClk);
        req.memRq = 1'b1;
        driveCable(c, req);
        pendReq[c] = req;
        pendActive[c] = 1'b1;
        rqCycle[c] = cycle;
        waited = 0;
        do begin
          @(negedge sbusClk);
          rsp = cableRsp(c);
          waited++;
        end while (!rsp.memAckn && waited < rspWait);
        if (!rsp.memAckn) begin
          protoErrors++;
          $display("Cable %0d got no memAckn within %0d cycles", c, rspWait);
          pendActive[c] = 1'b0;
        end
        @(posedge sbusClk);
        driveCable(c, '0);
        if (rsp.memAckn && req.rdRq && !rsp.memAdrParErr) begin
          waited = 0;
          do begin
            @(negedge sbusClk);
            rsp = cableRsp(c);
            waited++;
          end while (!rsp.memDataValid && waited < rspWait);
          if (!rsp.memDataValid) begin
            protoErrors++;
            $display("Cable %0d got no memDataValid for its read", c);
            pendActive[c] = 1'b0;
            inFlight[c] = 1'b0;
          end
        end else begin
          // Room for a stray data-valid to show up
          repeat (`READ_LATENCY + 1) @(negedge sbusClk);
        end
        @(posedge sbusClk);
        drvBusy[c] = 1'b0;
      end
    end
  endtask

  initial runCable(0);
  initial runCable(1);

  // Checks every ackn and data-valid pulse against the model
  task automatic compareCable(input int c);
    sbusPkg::mboxRspT rsp;
    refT exp;
    rsp = cableRsp(c);
    exp = refRead(pendReq[c].pa, pendReq[c].memAdrPar);
    if (rsp.memAckn) begin
      if (!pendActive[c] || inFlight[1 - c]) begin
        protoErrors++;
        $display("Unexpected memAckn on cable %0d at %0t ns", c, $time);
      end else begin
        checkFlag("memAdrParErr", exp.adrParErr, rsp.memAdrParErr);
        if (pendUncont[c]) begin
          checkNumber("memRq to memAckn cycles", 2, cycle - rqCycle[c]);
        end
        acknCycle[c] = cycle;
        inFlight[c] = 1'b1;
        if (pendReq[c].wrRq && !exp.adrParErr) begin
          modelWrite(pendReq[c]);
        end
        if (pendReq[c].wrRq || exp.adrParErr) begin
          finishTransfer(c);
        end
      end
    end
    if (rsp.memDataValid) begin
      if (!inFlight[c] || !pendReq[c].rdRq) begin
        protoErrors++;
        $display("Unexpected memDataValid on cable %0d at %0t ns", c, $time);
      end else begin
        checkWord("memDataIn", exp.word, rsp.memDataIn);
        checkFlag("memParIn", exp.par, rsp.memParIn);
        checkFlag("memError", exp.memError, rsp.memError);
        checkNumber("memAckn to memDataValid cycles", `READ_LATENCY - 1, cycle - acknCycle[c]);
        if (pendUncont[c]) begin
          // Acceptance is one edge after memRq
          checkNumber("memRq to memDataValid cycles", `READ_LATENCY + 1, cycle - rqCycle[c]);
        end
        finishTransfer(c);
      end
    end
  endtask

  always @(negedge sbusClk) begin
    if (rstN) begin
      // One storage response can only belong to one cable
      if ((mboxRsp0.memAckn && mboxRsp1.memAckn) ||
          (mboxRsp0.memDataValid && mboxRsp1.memDataValid)) begin
        protoErrors++;
        $display("Same response seen on both cables at %0t ns", $time);
      end
      for (int c = 0; c < 2; c++) begin
        compareCable(c);
      end
    end
  end

  // Loads a cable's command slot, called on a falling edge
  task automatic issue(input int c, input logic write, input sbusPkg::adrT adr,
                       input sbusPkg::wordT data, input logic parOk, input logic adrOk,
                       input logic uncont);
    sbusPkg::mboxReqT req;
    req = '0;
    req.rdRq = !write;
    req.wrRq = write;
    req.pa = adr;
    req.memAdrPar = adrOk ? ~^adr : ^adr;
    req.mb = write ? data : '0;
    req.memPar = parOk ? ~^data : ^data;
    cmd[c] = req;
    pendUncont[c] = uncont;
    cmdValid[c] = 1'b1;
  endtask

  task automatic waitIdle();
    do begin
      @(negedge sbusClk);
    end while (cmdValid[0] || cmdValid[1] || drvBusy[0] || drvBusy[1]);
  endtask

  task automatic single(input int c, input logic write, input sbusPkg::adrT adr,
                        input logic parOk, input logic adrOk);
    issue(c, write, adr, randWord(), parOk, adrOk, 1'b1);
    waitIdle();
  endtask

  // Random read address sharing the low bits of a written one
  function automatic sbusPkg::adrT aliasOf(input sbusPkg::adrT adr);
    sbusPkg::adrT a;
    a = randAdr();
    a[`STORE_ADR_BITS-1:0] = adr[`STORE_ADR_BITS-1:0];
    return a;
  endfunction

  initial begin
    sbusPkg::adrT wrAdr [8];
    sbusPkg::adrT adr;
    int winner;
    mbox0 <= '0;
    mbox1 <= '0;
    lastServed = 1'b1;
    for (int c = 0; c < 2; c++) begin
      cmdValid[c] = 1'b0;
      drvBusy[c] = 1'b0;
      pendActive[c] = 1'b0;
      inFlight[c] = 1'b0;
      pendUncont[c] = 1'b0;
      pendReq[c] = '0;
    end
    wait (rstN);
    repeat (2) @(negedge sbusClk);
    // Writes, each in its own eighth of the storage, then aliased reads
    for (int i = 0; i < 8; i++) begin
      adr = randAdr();
      adr[`STORE_ADR_BITS-1 -: 3] = 3'(i);
      wrAdr[i] = adr;
      single(0, 1'b1, adr, 1'b1, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      single(0, 1'b0, aliasOf(wrAdr[i]), 1'b1, 1'b1);
    end
    // Stored with bad data parity, read back with memError
    single(1, 1'b1, wrAdr[0], 1'b0, 1'b1);
    single(1, 1'b0, aliasOf(wrAdr[0]), 1'b1, 1'b1);
    // Bad address parity on a write and a read, then a clean read
    single(0, 1'b1, wrAdr[1], 1'b1, 1'b0);
    single(0, 1'b0, wrAdr[1], 1'b1, 1'b0);
    single(1, 1'b0, aliasOf(wrAdr[1]), 1'b1, 1'b1);
    // Both cables at once, order from the round-robin rule
    for (int i = 0; i < 4; i++) begin
      winner = lastServed ? 0 : 1;
      doneOrder.delete();
      issue(0, 1'b1, wrAdr[i + 4], randWord(), 1'b1, 1'b1, 1'b0);
      issue(1, 1'b0, wrAdr[i], '0, 1'b1, 1'b1, 1'b0);
      waitIdle();
      checkNumber("completions in pair", 2, doneOrder.size());
      checkNumber("first cable to complete", winner, (doneOrder.size() > 0) ? doneOrder[0] : -1);
      // Winner alone again so the next pair starts on the other cable
      single(winner, 1'b0, wrAdr[i + 4], 1'b1, 1'b1);
    end
    // Shared storage seen from the other cable
    adr = randAdr();
    single(0, 1'b1, adr, 1'b1, 1'b1);
    single(1, 1'b0, aliasOf(adr), 1'b1, 1'b1);
    repeat (4) @(negedge sbusClk);
    $display("Checks: %0d, value errors: %0d, response errors: %0d",
             checks, valueErrors, protoErrors);
    if (valueErrors == 0 && protoErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    wait (cycle >= timeoutCycles);
    $display("Run did not finish within %0d cycles", timeoutCycles);
    $display("Checks: %0d, value errors: %0d, response errors: %0d",
             checks, valueErrors, protoErrors);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== memSubsystem.f ====
+incdir+src
src/sbusPkg.sv
src/mbusTranslator.sv
src/sbusArbiter.sv
src/storageModule.sv
src/memSubsystem.sv
test/clockGen.sv
test/memSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: memSubsystem

sources:
  - include_dirs:
      - src
    files:
      - src/sbusPkg.sv
      - src/mbusTranslator.sv
      - src/sbusArbiter.sv
      - src/storageModule.sv
      - src/memSubsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/clockGen.sv
      - test/memSubsystemTb.sv
